//--- verilog/dmc_clk_pkg.sv
package dmc_clk_pkg;

  // serial tag packet fields
  localparam int tag_node_width_c    = 4;
  localparam int tag_payload_width_c = 8;

  // fixed node ids
  localparam logic [tag_node_width_c-1:0] node_async_reset_c = 4'd0;
  localparam logic [tag_node_width_c-1:0] node_ds_c          = 4'd1;

  // delay nodes start here, one per strobe line
  // the trigger nodes follow right after the last delay node
  localparam logic [tag_node_width_c-1:0] node_dly_base_c = 4'd2;

  // downsampler payload after reset
  // bit 7 holds the divider in reset, bits 1:0 are the divide value
  localparam logic [tag_payload_width_c-1:0] ds_reset_default_c = 8'h80;

  // serial receiver states
  typedef enum logic [1:0] {
    TAG_IDLE,
    TAG_NODE,
    TAG_KIND,
    TAG_PAYLOAD
  } tag_state_e;

endpackage

//--- verilog/tag_decode.sv
module tag_decode
  import dmc_clk_pkg::*;
  (input                                  clk_i
  ,input                                  reset_i
  // serial tag bit, idles low
  ,input                                  tag_data_i
  // one cycle strobe, fields below only valid with it
  ,output logic                           pkt_v_o
  ,output logic [tag_node_width_c-1:0]    pkt_node_o
  ,output logic                           pkt_data_not_reset_o
  ,output logic [tag_payload_width_c-1:0] pkt_payload_o
  );

  // counter covers the longest field, which is the payload
  localparam cnt_width_lp = $clog2(tag_payload_width_c);

  tag_state_e state_r;
  tag_state_e state_n;

  logic [cnt_width_lp-1:0] cnt_r;
  logic                    last_node_bit;
  logic                    last_payload_bit;

  assign last_node_bit    = (cnt_r == cnt_width_lp'(tag_node_width_c - 1));
  assign last_payload_bit = (cnt_r == cnt_width_lp'(tag_payload_width_c - 1));

  // next state
  always_comb begin
    state_n = state_r;
    case (state_r)
      TAG_IDLE: begin
        // start bit
        if (tag_data_i) begin
          state_n = TAG_NODE;
        end
      end
      TAG_NODE: begin
        if (last_node_bit) begin
          state_n = TAG_KIND;
        end
      end
      TAG_KIND: begin
        state_n = TAG_PAYLOAD;
      end
      TAG_PAYLOAD: begin
        if (last_payload_bit) begin
          state_n = TAG_IDLE;
        end
      end
      default: begin
        state_n = TAG_IDLE;
      end
    endcase
  end

  // control state
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= TAG_IDLE;
      cnt_r   <= '0;
      pkt_v_o <= 1'b0;
    end else begin
      state_r <= state_n;
      // bit count restarts at every field boundary
      if ((state_n == state_r) && (state_r != TAG_IDLE)) begin
        cnt_r <= cnt_r + 1'b1;
      end else begin
        cnt_r <= '0;
      end
      // strobe in the cycle right after the last payload bit
      pkt_v_o <= (state_r == TAG_PAYLOAD) && last_payload_bit;
    end
  end

  // field shift registers, msb arrives first
  always_ff @(posedge clk_i) begin
    if (state_r == TAG_NODE) begin
      pkt_node_o <= {pkt_node_o[tag_node_width_c-2:0], tag_data_i};
    end
    if (state_r == TAG_KIND) begin
      pkt_data_not_reset_o <= tag_data_i;
    end
    if (state_r == TAG_PAYLOAD) begin
      pkt_payload_o <= {pkt_payload_o[tag_payload_width_c-2:0], tag_data_i};
    end
  end

endmodule

//--- verilog/tag_client_regs.sv
module tag_client_regs
  import dmc_clk_pkg::*;
 #(parameter  num_lines_p  = 2
  ,parameter  num_adgs_p   = 2
  ,localparam tap_width_lp = $clog2(4*num_adgs_p))
  (input                                      clk_i
  ,input                                      reset_i
  // decoded packet from the receiver
  ,input                                      pkt_v_i
  ,input        [tag_node_width_c-1:0]        pkt_node_i
  ,input                                      pkt_data_not_reset_i
  ,input        [tag_payload_width_c-1:0]     pkt_payload_i
  // settings
  ,output logic                               async_reset_o
  ,output logic                               ds_reset_o
  ,output logic [1:0]                         ds_val_o
  ,output logic [num_lines_p*tap_width_lp-1:0] tap_o
  );

  localparam num_taps_lp = 4*num_adgs_p;
  localparam logic [tag_payload_width_c-1:0] max_tap_lp =
    tag_payload_width_c'(num_taps_lp - 1);

  logic                                     pkt_v_r;
  logic [tag_node_width_c-1:0]              node_r;
  logic                                     data_not_reset_r;
  logic [tag_payload_width_c-1:0]           payload_r;
  logic [tap_width_lp-1:0]                  clamped_tap;
  logic [num_lines_p-1:0][tap_width_lp-1:0] shadow_r;
  logic [num_lines_p-1:0][tap_width_lp-1:0] active_r;

  // packet capture stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pkt_v_r <= 1'b0;
    end else begin
      pkt_v_r <= pkt_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pkt_v_i) begin
      node_r           <= pkt_node_i;
      data_not_reset_r <= pkt_data_not_reset_i;
      payload_r        <= pkt_payload_i;
    end
  end

  // oversized taps saturate at the last stage
  assign clamped_tap = (payload_r > max_tap_lp) ? tap_width_lp'(max_tap_lp)
                                                : payload_r[tap_width_lp-1:0];

  // apply stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      async_reset_o <= 1'b1;
      ds_reset_o    <= ds_reset_default_c[7];
      ds_val_o      <= ds_reset_default_c[1:0];
      shadow_r      <= '0;
      active_r      <= '0;
    end else if (pkt_v_r) begin
      if (node_r == node_async_reset_c) begin
        async_reset_o <= data_not_reset_r ? payload_r[0] : 1'b1;
      end
      if (node_r == node_ds_c) begin
        if (data_not_reset_r) begin
          ds_reset_o <= payload_r[7];
          ds_val_o   <= payload_r[1:0];
        end else begin
          ds_reset_o <= ds_reset_default_c[7];
          ds_val_o   <= ds_reset_default_c[1:0];
        end
      end
      for (int i = 0; i < num_lines_p; i++) begin
        // delay write lands in the shadow, a reset packet clears both copies
        if (node_r == tag_node_width_c'(node_dly_base_c + i)) begin
          if (data_not_reset_r) begin
            shadow_r[i] <= clamped_tap;
          end else begin
            shadow_r[i] <= '0;
            active_r[i] <= '0;
          end
        end
        // trigger moves the shadow onto the line
        if (data_not_reset_r
            && (node_r == tag_node_width_c'(node_dly_base_c + num_lines_p + i))) begin
          active_r[i] <= shadow_r[i];
        end
      end
    end
  end

  assign tap_o = active_r;

endmodule

//--- verilog/dly_line.sv
module dly_line
 #(parameter  num_adgs_p   = 2
  ,localparam tap_width_lp = $clog2(4*num_adgs_p))
  (input                     clk_i
  ,input                     reset_i
  // selects how many extra cycles of delay
  ,input  [tap_width_lp-1:0] tap_i
  ,input                     line_i
  ,output logic              line_o
  );

  // four taps per delay stage
  localparam num_taps_lp = 4*num_adgs_p;

  // history of the line, bit 0 is the newest sample
  logic [num_taps_lp-1:0] hist_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      hist_r <= '0;
    end else begin
      hist_r <= {hist_r[num_taps_lp-2:0], line_i};
    end
  end

  // tap 0 is the line one cycle late
  // a new tap reselects from the history at once
  assign line_o = hist_r[tap_i];

endmodule

//--- verilog/clk_downsample.sv
module clk_downsample
  (input              clk_i
  // held high by the tag to park the divider
  ,input              ds_reset_i
  // output toggles every ds_val_i + 1 cycles
  ,input        [1:0] ds_val_i
  ,output logic       clk_div_o
  );

  logic [1:0] count_r;
  logic       count_done;

  assign count_done = (count_r == ds_val_i);

  always_ff @(posedge clk_i) begin
    if (ds_reset_i) begin
      count_r   <= '0;
      clk_div_o <= 1'b0;
    end else if (count_done) begin
      // half period reached
      count_r   <= '0;
      clk_div_o <= ~clk_div_o;
    end else begin
      count_r <= count_r + 1'b1;
    end
  end

endmodule

//--- verilog/dmc_clk_rst_gen.sv
module dmc_clk_rst_gen
  import dmc_clk_pkg::*;
 #(parameter num_lines_p = 2
  ,parameter num_adgs_p  = 2)
  (input                    clk_i
  ,input                    reset_i
  // serial configuration
  ,input                    tag_data_i
  // strobe lines in and delayed out
  ,input  [num_lines_p-1:0] line_i
  ,output [num_lines_p-1:0] line_o
  // reset level for the dram controller
  ,output                   async_reset_o
  // divided controller clock
  ,output                   div_clk_o
  );

  localparam tap_width_lp = $clog2(4*num_adgs_p);

  logic                                 pkt_v;
  logic [tag_node_width_c-1:0]          pkt_node;
  logic                                 pkt_data_not_reset;
  logic [tag_payload_width_c-1:0]       pkt_payload;
  logic                                 ds_reset;
  logic [1:0]                           ds_val;
  logic [num_lines_p*tap_width_lp-1:0]  tap;

  tag_decode decode
    (.clk_i                ( clk_i              )
    ,.reset_i              ( reset_i            )
    ,.tag_data_i           ( tag_data_i         )
    ,.pkt_v_o              ( pkt_v              )
    ,.pkt_node_o           ( pkt_node           )
    ,.pkt_data_not_reset_o ( pkt_data_not_reset )
    ,.pkt_payload_o        ( pkt_payload        ));

  tag_client_regs #
    (.num_lines_p ( num_lines_p )
    ,.num_adgs_p  ( num_adgs_p  ))
  regs
    (.clk_i                ( clk_i              )
    ,.reset_i              ( reset_i            )
    ,.pkt_v_i              ( pkt_v              )
    ,.pkt_node_i           ( pkt_node           )
    ,.pkt_data_not_reset_i ( pkt_data_not_reset )
    ,.pkt_payload_i        ( pkt_payload        )
    ,.async_reset_o        ( async_reset_o      )
    ,.ds_reset_o           ( ds_reset           )
    ,.ds_val_o             ( ds_val             )
    ,.tap_o                ( tap                ));

  // one delay line per strobe
  for (genvar i = 0; i < num_lines_p; i++) begin : dly_lines
    dly_line #(.num_adgs_p(num_adgs_p)) dly
      (.clk_i   ( clk_i                                )
      ,.reset_i ( reset_i                              )
      ,.tap_i   ( tap[i*tap_width_lp +: tap_width_lp]  )
      ,.line_i  ( line_i[i]                            )
      ,.line_o  ( line_o[i]                            ));
  end

  // controller clock, parked while the tag holds ds_reset
  clk_downsample ds
    (.clk_i      ( clk_i     )
    ,.ds_reset_i ( ds_reset  )
    ,.ds_val_i   ( ds_val    )
    ,.clk_div_o  ( div_clk_o ));

endmodule

//--- tests/dmc_clk_rst_checker.sv
module dmc_clk_rst_checker
  import dmc_clk_pkg::*;
 #(parameter num_lines_p = 2
  ,parameter num_adgs_p  = 2)
  (input                    clk_i
  ,input                    reset_i
  // stimulus seen by the DUT
  ,input                    tag_data_i
  ,input  [num_lines_p-1:0] line_i
  // DUT outputs under test
  ,input  [num_lines_p-1:0] line_o
  ,input                    async_reset_o
  ,input                    div_clk_o
  // mismatch counts and decoded packet count
  ,output int               async_errs_o
  ,output int               line_errs_o
  ,output int               div_errs_o
  ,output int               pkts_o
  );

  localparam num_taps_lp = 4*num_adgs_p;
  // node, kind and payload bits after the start bit
  localparam pkt_bits_lp = tag_node_width_c + 1 + tag_payload_width_c;

  // serial receiver model
  logic                   rx_busy;
  int                     rx_count;
  logic [pkt_bits_lp-1:0] rx_bits;

  // packet seen at edge N is applied at edge N+2
  logic                   s1_v;
  logic                   s2_v;
  logic [pkt_bits_lp-1:0] s1_bits;
  logic [pkt_bits_lp-1:0] s2_bits;

  // expected register state
  logic                           exp_async;
  logic [tag_payload_width_c-1:0] exp_ds;
  int                             shadow[num_lines_p];
  int                             active[num_lines_p];

  // expected divider state
  // two bit count, wraps past 3 when ds_val shrinks while running
  logic [1:0] half_count;
  logic       exp_div;

  // sampled line history, entry 0 is the latest edge
  logic [num_lines_p-1:0] hist [num_taps_lp];

  logic reset_seen = 1'b0;
  logic check_en   = 1'b0;

  function automatic int clamp_tap(input logic [tag_payload_width_c-1:0] payload);
    if (payload > num_taps_lp - 1) begin
      return num_taps_lp - 1;
    end
    return payload;
  endfunction

  task automatic apply_packet(input logic [pkt_bits_lp-1:0] bits);
    int                             node;
    logic                           dnr;
    logic [tag_payload_width_c-1:0] payload;
    node    = bits[pkt_bits_lp-1 -: tag_node_width_c];
    dnr     = bits[tag_payload_width_c];
    payload = bits[tag_payload_width_c-1:0];
    if (node == node_async_reset_c) begin
      exp_async = dnr ? payload[0] : 1'b1;
    end else if (node == node_ds_c) begin
      exp_ds = dnr ? payload : ds_reset_default_c;
    end
    for (int i = 0; i < num_lines_p; i++) begin
      if (node == node_dly_base_c + i) begin
        if (dnr) begin
          shadow[i] = clamp_tap(payload);
        end else begin
          shadow[i] = 0;
          active[i] = 0;
        end
      end
      // trigger only acts on a data packet
      if ((node == node_dly_base_c + num_lines_p + i) && dnr) begin
        active[i] = shadow[i];
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      rx_busy    = 1'b0;
      rx_count   = 0;
      s1_v       = 1'b0;
      s2_v       = 1'b0;
      exp_async  = 1'b1;
      exp_ds     = ds_reset_default_c;
      half_count = 0;
      exp_div    = 1'b0;
      for (int i = 0; i < num_lines_p; i++) begin
        shadow[i] = 0;
        active[i] = 0;
      end
      for (int k = 0; k < num_taps_lp; k++) begin
        hist[k] = '0;
      end
      reset_seen = 1'b1;
      check_en   = 1'b0;
    end else begin
      // divider acts on the settings held before this edge
      if (exp_ds[7]) begin
        half_count = 0;
        exp_div    = 1'b0;
      end else if (half_count == exp_ds[1:0]) begin
        half_count = 0;
        exp_div    = ~exp_div;
      end else begin
        half_count++;
      end
      for (int k = num_taps_lp-1; k > 0; k--) begin
        hist[k] = hist[k-1];
      end
      hist[0] = line_i;
      if (s2_v) begin
        apply_packet(s2_bits);
      end
      s2_v    = s1_v;
      s2_bits = s1_bits;
      s1_v    = 1'b0;
      // idle waits for a start bit, then 13 more bits make a packet
      if (!rx_busy) begin
        if (tag_data_i) begin
          rx_busy  = 1'b1;
          rx_count = 0;
        end
      end else begin
        rx_bits = {rx_bits[pkt_bits_lp-2:0], tag_data_i};
        rx_count++;
        if (rx_count == pkt_bits_lp) begin
          rx_busy = 1'b0;
          s1_v    = 1'b1;
          s1_bits = rx_bits;
          pkts_o++;
        end
      end
      check_en = reset_seen;
    end
  end

  // outputs settle after the rising edge, compare half a cycle later
  always @(negedge clk_i) begin
    logic exp_line;
    if (check_en) begin
      if (async_reset_o !== exp_async) begin
        async_errs_o++;
        $display("** Error at time %0t: async_reset_o expected %b, got %b",
                 $time, exp_async, async_reset_o);
      end
      if (div_clk_o !== exp_div) begin
        div_errs_o++;
        $display("** Error at time %0t: div_clk_o expected %b, got %b",
                 $time, exp_div, div_clk_o);
      end
      for (int i = 0; i < num_lines_p; i++) begin
        exp_line = hist[active[i]][i];
        if (line_o[i] !== exp_line) begin
          line_errs_o++;
          $display("** Error at time %0t: line_o[%0d] expected %b, got %b",
                   $time, i, exp_line, line_o[i]);
        end
      end
    end
  end

endmodule

//--- tests/tb_dmc_clk_rst_gen.sv
module tb_dmc_clk_rst_gen
  import dmc_clk_pkg::*;
  ();

  localparam num_lines_lp = 2;
  localparam num_adgs_lp  = 2;
  localparam num_pkts_lp  = 200;
  localparam pkt_len_lp   = 14;
  localparam max_gap_lp   = 5;
  localparam watchdog_lp  = num_pkts_lp*(pkt_len_lp + max_gap_lp) + 100;
  // nodes 0 up to the last trigger node are in use
  localparam used_nodes_lp = 2 + 2*num_lines_lp;

  logic                    clk_i;
  logic                    reset_i;
  logic                    tag_data_i;
  logic [num_lines_lp-1:0] line_i;
  logic [num_lines_lp-1:0] line_o;
  logic                    async_reset_o;
  logic                    div_clk_o;

  int     async_errs;
  int     line_errs;
  int     div_errs;
  int     pkts_decoded;
  int     other_errs;
  int     pkts_sent;
  integer seed;

  dmc_clk_rst_gen #
    (.num_lines_p ( num_lines_lp )
    ,.num_adgs_p  ( num_adgs_lp  ))
  u_dut
    (.clk_i         ( clk_i         )
    ,.reset_i       ( reset_i       )
    ,.tag_data_i    ( tag_data_i    )
    ,.line_i        ( line_i        )
    ,.line_o        ( line_o        )
    ,.async_reset_o ( async_reset_o )
    ,.div_clk_o     ( div_clk_o     ));

  dmc_clk_rst_checker #
    (.num_lines_p ( num_lines_lp )
    ,.num_adgs_p  ( num_adgs_lp  ))
  u_check
    (.clk_i         ( clk_i         )
    ,.reset_i       ( reset_i       )
    ,.tag_data_i    ( tag_data_i    )
    ,.line_i        ( line_i        )
    ,.line_o        ( line_o        )
    ,.async_reset_o ( async_reset_o )
    ,.div_clk_o     ( div_clk_o     )
    ,.async_errs_o  ( async_errs    )
    ,.line_errs_o   ( line_errs     )
    ,.div_errs_o    ( div_errs      )
    ,.pkts_o        ( pkts_decoded  ));

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // one serial bit per cycle, strobe lines get fresh random bits
  task automatic drive_cycle(input logic bit_v);
    @(posedge clk_i);
    #10;
    tag_data_i = bit_v;
    line_i     = num_lines_lp'($random(seed));
  endtask

  task automatic send_packet(input logic [tag_node_width_c-1:0]    node
                            ,input logic                           dnr
                            ,input logic [tag_payload_width_c-1:0] payload
                            ,input int                             gap);
    drive_cycle(1'b1);
    for (int b = tag_node_width_c-1; b >= 0; b--) begin
      drive_cycle(node[b]);
    end
    drive_cycle(dnr);
    for (int b = tag_payload_width_c-1; b >= 0; b--) begin
      drive_cycle(payload[b]);
    end
    repeat (gap) drive_cycle(1'b0);
    pkts_sent++;
  endtask

  task automatic send_random_packet();
    logic [tag_node_width_c-1:0]    node;
    logic                           dnr;
    logic [tag_payload_width_c-1:0] payload;
    int                             gap;
    // three out of four packets go to a node that is in use
    if (({$random(seed)} % 4) != 0) begin
      node = {$random(seed)} % used_nodes_lp;
    end else begin
      node = {$random(seed)} % 16;
    end
    dnr     = (({$random(seed)} % 8) != 0);
    payload = $random(seed);
    gap     = {$random(seed)} % (max_gap_lp + 1);
    send_packet(node, dnr, payload, gap);
  endtask

  initial begin
    int total;
    seed       = 32'h17f2_535b;
    reset_i    = 1'b1;
    tag_data_i = 1'b0;
    line_i     = '0;
    other_errs = 0;
    pkts_sent  = 0;
    repeat (4) drive_cycle(1'b0);
    reset_i = 1'b0;
    repeat (3) drive_cycle(1'b0);

    // divider running with a period of 4 cycles
    send_packet(node_ds_c, 1'b1, 8'h01, 3);
    // delay write then trigger, back to back
    send_packet(node_dly_base_c, 1'b1, 8'h03, 0);
    send_packet(node_dly_base_c + num_lines_lp, 1'b1, 8'h00, 2);
    // oversized tap on line 1 saturates
    send_packet(node_dly_base_c + 1, 1'b1, 8'h2a, 0);
    send_packet(node_dly_base_c + num_lines_lp + 1, 1'b1, 8'h00, 5);
    send_packet(node_async_reset_c, 1'b1, 8'h00, 1);
    // unused node must not change anything
    send_packet(4'd15, 1'b1, 8'hff, 0);
    send_packet(node_async_reset_c, 1'b0, 8'h00, 4);

    while (pkts_sent < num_pkts_lp) begin
      send_random_packet();
    end
    // let the last packet take effect
    repeat (20) drive_cycle(1'b0);

    if (pkts_decoded != pkts_sent) begin
      other_errs++;
      $display("packet count does not match: sent %0d, reference decoded %0d",
               pkts_sent, pkts_decoded);
    end
    total = async_errs + line_errs + div_errs + other_errs;
    $display("errors: async_reset_o %0d, line_o %0d, div_clk_o %0d, other %0d, total %0d",
             async_errs, line_errs, div_errs, other_errs, total);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // bound from the worst case packet length plus gap
  initial begin
    repeat (watchdog_lp) @(posedge clk_i);
    $display("watchdog expired after %0d cycles before the stimulus finished", watchdog_lp);
    $display("test failed");
    $finish;
  end

endmodule

//--- dmc_clk_rst_gen.f
verilog/dmc_clk_pkg.sv
verilog/tag_decode.sv
verilog/tag_client_regs.sv
verilog/dly_line.sv
verilog/clk_downsample.sv
verilog/dmc_clk_rst_gen.sv
tests/dmc_clk_rst_checker.sv
tests/tb_dmc_clk_rst_gen.sv
